// ==== hw/video_pkg.sv ====
/*
  Shared raster timing, width types and phase encoding for the video driver.
  Every RTL block imports this package with a wildcard import.
*/
package video_pkg;

  // Horizontal timing in pixel clocks
  localparam int H_ACTIVE = 16;
  localparam int H_FP     = 4;
  localparam int H_SYNC   = 3;
  localparam int H_BP     = 5;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

  // Vertical timing in lines
  localparam int V_ACTIVE = 6;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 3;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

  // Last count of each phase, region order is FP, SYNC, BP, ACTIVE
  localparam int H_FP_LAST   = H_FP - 1;
  localparam int H_SYNC_LAST = H_FP + H_SYNC - 1;
  localparam int H_BP_LAST   = H_FP + H_SYNC + H_BP - 1;
  localparam int H_LAST      = H_TOTAL - 1;

  localparam int V_FP_LAST   = V_FP - 1;
  localparam int V_SYNC_LAST = V_FP + V_SYNC - 1;
  localparam int V_BP_LAST   = V_FP + V_SYNC + V_BP - 1;
  localparam int V_LAST      = V_TOTAL - 1;

  // 0 gives active low syncs
  localparam bit SYNC_ACTIVE_HIGH = 1'b0;

  // Pixel FIFO entries, power of two
  localparam int FIFO_DEPTH = 32;

  // One RGB888 word
  typedef logic [23:0] pixel_t;

  typedef logic [$clog2(H_TOTAL)-1:0] hcount_t;
  typedef logic [$clog2(V_TOTAL)-1:0] vcount_t;

  // Needs one extra bit to hold FIFO_DEPTH itself
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level_t;

  typedef enum logic [2:0] {
    IDLE,
    FRONT_PORCH,
    SYNC,
    BACK_PORCH,
    ACTIVE
  } raster_phase_t;

endpackage

// ==== hw/raster_counter.sv ====
/*
  Pixel and line counters of the raster. Counts run while the phase FSMs
  are out of IDLE and clear otherwise.
*/
`timescale 1ns/100ps

module raster_counter
  import video_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    run,
  output hcount_t hcount,
  output vcount_t vcount,
  output logic    line_end
);

  // Last pixel clock of a line
  assign line_end = (hcount == hcount_t'(H_LAST));

  // Pixel counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hcount <= '0;
    end
    else if (!run)
    begin
      hcount <= '0;
    end
    else if (line_end)
    begin
      hcount <= '0;
    end
    else
    begin
      hcount <= hcount + 1'b1;
    end
  end

  // Line counter, steps once per line
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vcount <= '0;
    end
    else if (!run)
    begin
      vcount <= '0;
    end
    else if (line_end)
    begin
      // Frame wrap on the last line
      if (vcount == vcount_t'(V_LAST))
        vcount <= '0;
      else
        vcount <= vcount + 1'b1;
    end
  end

endmodule

// ==== hw/raster_phase_fsm.sv ====
/*
  Horizontal and vertical phase FSMs of the raster. Both walk front porch,
  sync, back porch and active video from the counter positions.
*/
`timescale 1ns/100ps

module raster_phase_fsm
  import video_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          drvr_en,
  input  hcount_t       hcount,
  input  vcount_t       vcount,
  input  logic          line_end,
  output logic          run,
  output raster_phase_t h_phase,
  output raster_phase_t v_phase
);

  raster_phase_t h_next;
  raster_phase_t v_next;

  // Common phase step, each flag marks the last count of its region
  function automatic raster_phase_t next_phase(
    input raster_phase_t cur,
    input logic          fp_end,
    input logic          sync_end,
    input logic          bp_end,
    input logic          act_end
  );
    next_phase = cur;
    case (cur)
      IDLE:        next_phase = FRONT_PORCH;
      FRONT_PORCH: if (fp_end)   next_phase = SYNC;
      SYNC:        if (sync_end) next_phase = BACK_PORCH;
      BACK_PORCH:  if (bp_end)   next_phase = ACTIVE;
      ACTIVE:      if (act_end)  next_phase = FRONT_PORCH;
      default:     next_phase = IDLE;
    endcase
  endfunction

  // Horizontal machine steps on every pixel clock
  always_comb
  begin
    if (!drvr_en)
      h_next = IDLE;
    else
      h_next = next_phase(h_phase,
                          hcount == hcount_t'(H_FP_LAST),
                          hcount == hcount_t'(H_SYNC_LAST),
                          hcount == hcount_t'(H_BP_LAST),
                          line_end);
  end

  // Vertical machine moves only at line end, except leaving IDLE
  always_comb
  begin
    if (!drvr_en)
      v_next = IDLE;
    else
      v_next = next_phase(v_phase,
                          line_end && (vcount == vcount_t'(V_FP_LAST)),
                          line_end && (vcount == vcount_t'(V_SYNC_LAST)),
                          line_end && (vcount == vcount_t'(V_BP_LAST)),
                          line_end && (vcount == vcount_t'(V_LAST)));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      h_phase <= IDLE;
      v_phase <= IDLE;
    end
    else
    begin
      h_phase <= h_next;
      v_phase <= v_next;
    end
  end

  // Counters hold at zero while idle
  assign run = (h_phase != IDLE);

endmodule

// ==== hw/pixel_fifo.sv ====
/*
  Show-ahead pixel FIFO between the pixel source and the video output.
  The head word sits on rd_data; rd_en pops it. flush empties the FIFO.
*/
`timescale 1ns/100ps

module pixel_fifo
  import video_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   flush,
  input  logic   wr_en,
  input  pixel_t wr_data,
  output logic   full,
  input  logic   rd_en,
  output pixel_t rd_data,
  output logic   empty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  pixel_t      mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  fifo_level_t level;
  logic        wr_ok;
  logic        rd_ok;

  assign full  = (level == fifo_level_t'(FIFO_DEPTH));
  assign empty = (level == '0);

  // Writes while full and reads while empty are ignored
  assign wr_ok = wr_en && !full && !flush;
  assign rd_ok = rd_en && !empty && !flush;

  // Head word visible without a read
  assign rd_data = mem[rd_ptr];

  // Storage array
  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wr_ptr] <= wr_data;
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop keep the level
      case ({wr_ok, rd_ok})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

// ==== hw/video_out_stage.sv ====
/*
  Output stage toward the HDMI transmitter. Issues the FIFO pop in active
  video and registers data, data enable and syncs, plus the underflow flag.
*/
`timescale 1ns/100ps

module video_out_stage
  import video_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          drvr_en,
  input  raster_phase_t h_phase,
  input  raster_phase_t v_phase,
  input  pixel_t        rd_data,
  input  logic          empty,
  output logic          rd_en,
  output pixel_t        tx_data,
  output logic          tx_de,
  output logic          tx_hsync,
  output logic          tx_vsync,
  output logic          underflow
);

  logic active;

  // Inside the visible window
  assign active = (h_phase == ACTIVE) && (v_phase == ACTIVE);

  // One pop per active pixel when a word is there
  assign rd_en = active && !empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_data  <= '0;
      tx_de    <= 1'b0;
      tx_hsync <= ~SYNC_ACTIVE_HIGH;
      tx_vsync <= ~SYNC_ACTIVE_HIGH;
    end
    else
    begin
      tx_de    <= active;
      tx_hsync <= (h_phase == SYNC) ? SYNC_ACTIVE_HIGH : ~SYNC_ACTIVE_HIGH;
      tx_vsync <= (v_phase == SYNC) ? SYNC_ACTIVE_HIGH : ~SYNC_ACTIVE_HIGH;
      // Blank outside active video and on a missing pixel
      if (rd_en)
        tx_data <= rd_data;
      else
        tx_data <= '0;
    end
  end

  // Sticky until the driver is disabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      underflow <= 1'b0;
    else if (!drvr_en)
      underflow <= 1'b0;
    else if (active && empty)
      underflow <= 1'b1;
  end

endmodule

// ==== hw/video_drvr_top.sv ====
/*
  Raster video driver top for a parallel RGB HDMI transmitter.
  Connects the pixel FIFO, raster counter, phase FSMs and output stage.
*/
`timescale 1ns/100ps

module video_drvr_top
  import video_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   drvr_en,
  input  logic   wr_en,
  input  pixel_t wr_data,
  output logic   full,
  output pixel_t tx_data,
  output logic   tx_de,
  output logic   tx_hsync,
  output logic   tx_vsync,
  output logic   underflow
);

  logic          run;
  hcount_t       hcount;
  vcount_t       vcount;
  logic          line_end;
  raster_phase_t h_phase;
  raster_phase_t v_phase;
  logic          rd_en;
  pixel_t        rd_data;
  logic          empty;
  logic          flush;

  // FIFO drains while the driver is off
  assign flush = ~drvr_en;

  raster_counter u_counter (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .hcount   (hcount),
    .vcount   (vcount),
    .line_end (line_end)
  );

  raster_phase_fsm u_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .drvr_en  (drvr_en),
    .hcount   (hcount),
    .vcount   (vcount),
    .line_end (line_end),
    .run      (run),
    .h_phase  (h_phase),
    .v_phase  (v_phase)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty)
  );

  video_out_stage u_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .drvr_en   (drvr_en),
    .h_phase   (h_phase),
    .v_phase   (v_phase),
    .rd_data   (rd_data),
    .empty     (empty),
    .rd_en     (rd_en),
    .tx_data   (tx_data),
    .tx_de     (tx_de),
    .tx_hsync  (tx_hsync),
    .tx_vsync  (tx_vsync),
    .underflow (underflow)
  );

endmodule

// ==== verification/video_drvr_assertions.sv ====
/*
  Concurrent checks on the transmitter outputs, bound into the output stage.
  Blanking, sync versus data enable, and the sticky underflow flag.
*/
`timescale 1ns/100ps

module video_drvr_assertions
  import video_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input logic   drvr_en,
  input pixel_t tx_data,
  input logic   tx_de,
  input logic   tx_hsync,
  input logic   underflow
);

  // Number of failed assertions
  int fail_count = 0;

  // Data is blanked outside the active window
  blank_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_de |-> (tx_data == '0)
  ) else
  begin
    $error("tx_data nonzero while tx_de low");
    fail_count++;
  end

  // Active video never opens inside an hsync pulse
  de_not_in_sync: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(tx_de) |-> (tx_hsync != SYNC_ACTIVE_HIGH)
  ) else
  begin
    $error("tx_de rose during hsync");
    fail_count++;
  end

  // Underflow holds while the driver stays on
  underflow_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    (underflow && drvr_en) |=> underflow
  ) else
  begin
    $error("underflow cleared while drvr_en high");
    fail_count++;
  end

endmodule

bind video_out_stage video_drvr_assertions u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .drvr_en   (drvr_en),
  .tx_data   (tx_data),
  .tx_de     (tx_de),
  .tx_hsync  (tx_hsync),
  .underflow (underflow)
);

// ==== verification/tb_video_drvr.sv ====
/*
  Testbench for the raster video driver top. Runs a table of enable and source
  rows, predicts every output from a cycle model of the raster and checks it.
*/
`timescale 1ns/100ps

module tb_video_drvr;
  import video_pkg::*;

  localparam int FRAME = H_TOTAL * V_TOTAL;
  localparam int NROWS = 5;

  typedef struct {
    bit en;
    int frames;
    bit starve;
    int limit;
    bit uf;
  } row_t;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   drvr_en;
  logic   wr_en;
  pixel_t wr_data;
  logic   full;
  pixel_t tx_data;
  logic   tx_de;
  logic   tx_hsync;
  logic   tx_vsync;
  logic   underflow;

  row_t   rows [NROWS];
  pixel_t exp_q [$];
  logic [31:0] lfsr;
  int     val_errors;
  int     other_errors;
  int     cycles;
  int     limit;
  int     written;
  bit     accepted;

  // Cycle model of the raster holding the state after the last edge
  bit     m_run;
  int     m_h;
  int     m_v;
  // Expected outputs for the current cycle
  bit     exp_de;
  bit     exp_hs;
  bit     exp_vs;
  bit     exp_uf;
  pixel_t exp_data;

  // Pulse width monitor state
  int     ncyc;
  int     hs_low;
  int     vs_low;
  int     de_len;
  int     hs_rise;
  bit     hs_rise_ok;
  logic   hs_d;
  logic   vs_d;
  logic   de_d;

  video_drvr_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .drvr_en   (drvr_en),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .full      (full),
    .tx_data   (tx_data),
    .tx_de     (tx_de),
    .tx_hsync  (tx_hsync),
    .tx_vsync  (tx_vsync),
    .underflow (underflow)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output pixel_t w);
    for (int i = 0; i < 24; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w = {w[22:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      val_errors++;
      $display("Fail %s at cycle %0d: got %h expected %h", name, ncyc, got, exp);
    end
  endtask

  task automatic check_timing(input bit ok, input string what);
    if (!ok)
    begin
      other_errors++;
      $display("Timing error at cycle %0d: %s", ncyc, what);
    end
  endtask

  // True while a count sits in the sync region
  function automatic bit in_sync(input int c, input int fp, input int sy);
    in_sync = (c >= fp) && (c < fp + sy);
  endfunction

  // Reference model stepping with the DUT on each rising edge
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_run = 0;
      m_h = 0;
      m_v = 0;
      exp_de = 0;
      exp_hs = ~SYNC_ACTIVE_HIGH;
      exp_vs = ~SYNC_ACTIVE_HIGH;
      exp_uf = 0;
      exp_data = '0;
      exp_q.delete();
    end
    else
    begin
      // Outputs reflect the phase held before this edge
      exp_de = m_run && (m_h >= H_TOTAL - H_ACTIVE) && (m_v >= V_TOTAL - V_ACTIVE);
      exp_hs = (m_run && in_sync(m_h, H_FP, H_SYNC)) ? SYNC_ACTIVE_HIGH : ~SYNC_ACTIVE_HIGH;
      exp_vs = (m_run && in_sync(m_v, V_FP, V_SYNC)) ? SYNC_ACTIVE_HIGH : ~SYNC_ACTIVE_HIGH;
      exp_data = '0;
      if (exp_de && exp_q.size() > 0)
        exp_data = exp_q.pop_front();
      else if (exp_de && drvr_en)
        exp_uf = 1;
      if (!drvr_en)
      begin
        exp_uf = 0;
        exp_q.delete();
        m_run = 0;
        m_h = 0;
        m_v = 0;
      end
      else
      begin
        if (accepted)
          exp_q.push_back(wr_data);
        if (!m_run)
        begin
          // Leaving IDLE with both counts at zero
          m_run = 1;
        end
        else if (m_h == H_TOTAL - 1)
        begin
          m_h = 0;
          m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
        end
        else
          m_h = m_h + 1;
      end
    end
  end

  // Checks on stable values between edges
  always @(negedge clk)
  begin
    ncyc++;
    accepted = wr_en && !full && drvr_en;
    check_value("tx_de", 32'(tx_de), 32'(exp_de));
    check_value("tx_hsync", 32'(tx_hsync), 32'(exp_hs));
    check_value("tx_vsync", 32'(tx_vsync), 32'(exp_vs));
    check_value("tx_data", 32'(tx_data), 32'(exp_data));
    check_value("underflow", 32'(underflow), 32'(exp_uf));
    check_value("full", 32'(full), 32'(exp_q.size() == FIFO_DEPTH));
    // hsync width, line period and back porch before data enable
    if (tx_hsync == SYNC_ACTIVE_HIGH)
      hs_low++;
    else if (hs_d == SYNC_ACTIVE_HIGH)
    begin
      check_timing(hs_low == H_SYNC, "hsync pulse width");
      if (hs_rise_ok)
        check_timing(ncyc - hs_rise == H_TOTAL, "hsync period");
      hs_rise = ncyc;
      hs_rise_ok = 1;
      hs_low = 0;
    end
    if (tx_vsync == SYNC_ACTIVE_HIGH)
      vs_low++;
    else if (vs_d == SYNC_ACTIVE_HIGH)
    begin
      check_timing(vs_low == V_SYNC * H_TOTAL, "vsync pulse width");
      vs_low = 0;
    end
    if (tx_de)
    begin
      if (!de_d)
        check_timing(hs_rise_ok && ncyc - hs_rise == H_BP, "data enable start");
      de_len++;
    end
    else if (de_d)
    begin
      check_timing(de_len == H_ACTIVE, "active pixels per line");
      de_len = 0;
    end
    if (!drvr_en)
      hs_rise_ok = 0;
    hs_d = tx_hsync;
    vs_d = tx_vsync;
    de_d = tx_de;
  end

  // Run limit from the table length
  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("Timeout: run went past %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    pixel_t w;
    int     assert_errors;
    rst_n = 0;
    drvr_en = 0;
    wr_en = 0;
    wr_data = '0;
    lfsr = 32'h0e6c_6fba;
    val_errors = 0;
    other_errors = 0;
    cycles = 0;
    ncyc = 0;
    accepted = 0;
    hs_low = 0;
    vs_low = 0;
    de_len = 0;
    hs_rise = 0;
    hs_rise_ok = 0;
    hs_d = ~SYNC_ACTIVE_HIGH;
    vs_d = ~SYNC_ACTIVE_HIGH;
    de_d = 0;
    // en, frames, starve, pixel limit, expected underflow
    rows[0] = '{1, 2, 0, 0, 0};
    rows[1] = '{0, 1, 0, 0, 0};
    rows[2] = '{1, 2, 1, 40, 1};
    rows[3] = '{0, 1, 0, 0, 0};
    rows[4] = '{1, 1, 0, 0, 0};
    limit = 200;
    for (int r = 0; r < NROWS; r++)
      limit += rows[r].frames * FRAME;
    next_word(w);
    repeat (16) @(posedge clk);
    #1 rst_n = 1;
    for (int r = 0; r < NROWS; r++)
    begin
      written = 0;
      repeat (rows[r].frames * FRAME)
      begin
        @(posedge clk);
        #1;
        // Advance the source word once the last one went in
        if (accepted)
        begin
          written++;
          next_word(w);
        end
        drvr_en = rows[r].en;
        wr_data = w;
        wr_en = rows[r].en && !(rows[r].starve && written >= rows[r].limit);
      end
      if (underflow !== rows[r].uf)
      begin
        val_errors++;
        $display("Fail underflow at end of row %0d: got %h expected %h",
                 r, underflow, rows[r].uf);
      end
    end
    @(negedge clk);
    assert_errors = u_dut.u_out.u_assert.fail_count;
    $display("Errors: %0d value, %0d timing, %0d assertion", val_errors, other_errors,
             assert_errors);
    if (val_errors == 0 && other_errors == 0 && assert_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sim.f ====
hw/video_pkg.sv
hw/raster_counter.sv
hw/raster_phase_fsm.sv
hw/pixel_fifo.sv
hw/video_out_stage.sv
hw/video_drvr_top.sv
verification/video_drvr_assertions.sv
verification/tb_video_drvr.sv

// ==== Makefile ====
# Verilator build and run for the video driver testbench

VERILATOR ?= verilator
TOP       ?= tb_video_drvr
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
